// ==== source/key_extract_consts.svh ====
`ifndef KEY_EXTRACT_CONSTS_SVH
`define KEY_EXTRACT_CONSTS_SVH

// ======================================================================
// datapath widths
// ======================================================================
`define CTRL_DATA_W   256
`define PHV_W         768
`define KEY_W         192
`define OFF_W         18
`define SEL_W         3
`define C6_W          48
`define C4_W          32
`define C2_W          16

// table geometry, address taken from vlan id bits 8:4
`define TBL_AW        5
`define VLAN_W        12
`define VLAN_ADDR_LSB 4

// ======================================================================
// control header layout
// ======================================================================
`define HDR_FLAG_LSB  64
`define HDR_MODID_LSB 112
`define HDR_RESV_LSB  120
`define HDR_INDEX_LSB 128

`define CTRL_FLAG     16'hf2f1
`define STAGE_ID      0
`define KEY_EX_ID     1

`endif

// ==== source/phv_pkg.sv ====
`include "key_extract_consts.svh"

package phv_pkg;

	typedef logic [`SEL_W-1:0] sel_t;

	// six container selectors, 6B pair first
	typedef struct packed {
		sel_t s6_0;
		sel_t s6_1;
		sel_t s4_0;
		sel_t s4_1;
		sel_t s2_0;
		sel_t s2_1;
	} off_entry_t;

	// 6B group on top, then 4B, then 2B
	typedef logic [`PHV_W-1:0] phv_t;

	typedef struct packed {
		logic [`C6_W-1:0] f6_0;
		logic [`C6_W-1:0] f6_1;
		logic [`C4_W-1:0] f4_0;
		logic [`C4_W-1:0] f4_1;
		logic [`C2_W-1:0] f2_0;
		logic [`C2_W-1:0] f2_1;
	} key_t;

endpackage

// ==== source/ctrl_pkg.sv ====
`include "key_extract_consts.svh"

package ctrl_pkg;

	import phv_pkg::*;

	// header beat, msb first
	typedef struct packed {
		logic [`CTRL_DATA_W-`HDR_INDEX_LSB-9:0]        rsvd_hi;
		logic [7:0]                                    index;
		logic [`HDR_INDEX_LSB-`HDR_RESV_LSB-5:0]       rsvd_pad;
		logic [3:0]                                    resv;
		logic [7:0]                                    mod_id;
		logic [`HDR_MODID_LSB-`HDR_FLAG_LSB-17:0]      rsvd_mid;
		logic [15:0]                                   flag;
		logic [`HDR_FLAG_LSB-1:0]                      rsvd_lo;
	} ctrl_hdr_t;

	typedef struct packed {
		off_entry_t                  ent;
		logic [`KEY_W-`OFF_W-1:0]    rsvd;
	} off_view_t;

	// upper 192 bits of a swapped data beat
	typedef union packed {
		off_view_t off;
		key_t      mask;
	} tbl_entry_u;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WR_OFF,
		ST_WR_MASK,
		ST_FWD
	} ctrl_state_t;

endpackage

// ==== source/key_field_select.sv ====
`timescale 1ns/1ps

module key_field_select import phv_pkg::*; #(
	parameter int FIELD_W = 48
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    advance,
	input  logic [7:0][FIELD_W-1:0] group,
	input  sel_t                    sel,
	input  logic [FIELD_W-1:0]      mask,
	output logic [FIELD_W-1:0]      field
);

	// stage 2: one container out of eight, masked
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			field <= '0;
		end else if (advance) begin
			field <= group[sel] & mask;
		end
	end

endmodule

// ==== source/key_lookup.sv ====
`timescale 1ns/1ps
`include "key_extract_consts.svh"

module key_lookup import ctrl_pkg::*, phv_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               advance,
	input  logic [`VLAN_W-1:0] vlan_in,
	input  phv_t               phv_in,
	input  logic               phv_valid_in,
	input  logic               tbl_we_off,
	input  logic               tbl_we_mask,
	input  logic [`TBL_AW-1:0] tbl_addr,
	input  tbl_entry_u         tbl_entry,
	output phv_t               phv_q,
	output logic               valid_q,
	output off_entry_t         off_q,
	output key_t               mask_q
);
	off_entry_t         off_mem  [2**`TBL_AW];
	key_t               mask_mem [2**`TBL_AW];
	logic [`TBL_AW-1:0] rd_addr;

	assign rd_addr = vlan_in[`VLAN_ADDR_LSB +: `TBL_AW];

	// write side, one entry per pulse
	always_ff @(posedge clk) begin
		if (tbl_we_off) begin
			off_mem[tbl_addr] <= tbl_entry.off.ent;
		end
		if (tbl_we_mask) begin
			mask_mem[tbl_addr] <= tbl_entry.mask;
		end
	end

	// stage 1: table read aligned with the phv
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			phv_q <= '0;
			off_q <= '0;
			mask_q <= '0;
		end else if (advance) begin
			valid_q <= phv_valid_in;
			phv_q <= phv_in;
			off_q <= off_mem[rd_addr];
			mask_q <= mask_mem[rd_addr];
		end
	end

endmodule

// ==== source/ctrl_table_writer.sv ====
`timescale 1ns/1ps
`include "key_extract_consts.svh"

module ctrl_table_writer import ctrl_pkg::*, phv_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`CTRL_DATA_W-1:0] c_s_axis_tdata,
	input  logic                    c_s_axis_tvalid,
	input  logic                    c_s_axis_tlast,
	output logic [`CTRL_DATA_W-1:0] c_m_axis_tdata,
	output logic                    c_m_axis_tvalid,
	output logic                    c_m_axis_tlast,
	output logic                    tbl_we_off,
	output logic                    tbl_we_mask,
	output logic [`TBL_AW-1:0]      tbl_addr,
	output tbl_entry_u              tbl_entry
);
	ctrl_state_t             state;
	ctrl_hdr_t               hdr;
	logic [`CTRL_DATA_W-1:0] swapped;
	logic                    is_tbl;
	logic                    fwd_beat;
	logic                    first_beat;

	assign hdr = ctrl_hdr_t'(c_s_axis_tdata);

	// header addressed to this extractor and carrying at least one entry
	assign is_tbl = (hdr.mod_id[7:3] == 5'(`STAGE_ID)) &&
		(hdr.mod_id[2:0] == 3'(`KEY_EX_ID)) &&
		(hdr.flag == `CTRL_FLAG) && !c_s_axis_tlast;

	assign fwd_beat = c_s_axis_tvalid &&
		((state == ST_FWD) || (state == ST_IDLE && !is_tbl));

	// table data arrives little endian
	always_comb begin
		for (int b = 0; b < `CTRL_DATA_W/8; b++) begin
			swapped[8*b +: 8] = c_s_axis_tdata[`CTRL_DATA_W-8-8*b +: 8];
		end
	end

	// ==================================================================
	// pass-through of foreign packets
	// ==================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			c_m_axis_tdata <= '0;
			c_m_axis_tvalid <= 1'b0;
			c_m_axis_tlast <= 1'b0;
		end else begin
			c_m_axis_tvalid <= fwd_beat;
			if (fwd_beat) begin
				c_m_axis_tdata <= c_s_axis_tdata;
				c_m_axis_tlast <= c_s_axis_tlast;
			end
		end
	end

	// ==================================================================
	// packet fsm and table writes
	// ==================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			tbl_we_off <= 1'b0;
			tbl_we_mask <= 1'b0;
			tbl_addr <= '0;
			tbl_entry <= '0;
			first_beat <= 1'b0;
		end else begin
			tbl_we_off <= 1'b0;
			tbl_we_mask <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (c_s_axis_tvalid) begin
						if (is_tbl) begin
							tbl_addr <= hdr.index[`TBL_AW-1:0];
							first_beat <= 1'b1;
							// resv zero selects the offset table
							state <= (hdr.resv == 4'd0) ? ST_WR_OFF : ST_WR_MASK;
						end else if (!c_s_axis_tlast) begin
							state <= ST_FWD;
						end
					end
				end
				ST_WR_OFF, ST_WR_MASK: begin
					if (c_s_axis_tvalid) begin
						tbl_entry <= tbl_entry_u'(swapped[`CTRL_DATA_W-1 -: `KEY_W]);
						tbl_we_off <= (state == ST_WR_OFF);
						tbl_we_mask <= (state == ST_WR_MASK);
						first_beat <= 1'b0;
						// first entry lands on the header index
						if (!first_beat) begin
							tbl_addr <= tbl_addr + `TBL_AW'(1);
						end
						if (c_s_axis_tlast) begin
							state <= ST_IDLE;
						end
					end
				end
				ST_FWD: begin
					if (c_s_axis_tvalid && c_s_axis_tlast) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== source/key_assemble.sv ====
`timescale 1ns/1ps
`include "key_extract_consts.svh"

module key_assemble import phv_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             advance,
	input  phv_t             phv_q,
	input  logic             valid_q,
	input  logic [`C6_W-1:0] field_6b_0,
	input  logic [`C6_W-1:0] field_6b_1,
	input  logic [`C4_W-1:0] field_4b_0,
	input  logic [`C4_W-1:0] field_4b_1,
	input  logic [`C2_W-1:0] field_2b_0,
	input  logic [`C2_W-1:0] field_2b_1,
	output phv_t             phv_out,
	output logic             phv_valid_out,
	output key_t             key_out_masked,
	output logic             key_valid_out
);
	// phv copy riding alongside the field stage
	phv_t phv_d;
	logic valid_d;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phv_d <= '0;
			valid_d <= 1'b0;
			phv_out <= '0;
			phv_valid_out <= 1'b0;
			key_out_masked <= '0;
			key_valid_out <= 1'b0;
		end else if (advance) begin
			phv_d <= phv_q;
			valid_d <= valid_q;
			// stage 3
			phv_out <= phv_d;
			phv_valid_out <= valid_d;
			key_out_masked <= {field_6b_0, field_6b_1, field_4b_0, field_4b_1,
				field_2b_0, field_2b_1};
			key_valid_out <= valid_d;
		end
	end

endmodule

// ==== source/key_extract_top.sv ====
`timescale 1ns/1ps
`include "key_extract_consts.svh"

module key_extract_top import ctrl_pkg::*, phv_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`VLAN_W-1:0]      vlan_in,
	input  phv_t                    phv_in,
	input  logic                    phv_valid_in,
	output logic                    ready_out,
	output phv_t                    phv_out,
	output logic                    phv_valid_out,
	output key_t                    key_out_masked,
	output logic                    key_valid_out,
	input  logic                    ready_in,
	input  logic [`CTRL_DATA_W-1:0] c_s_axis_tdata,
	input  logic                    c_s_axis_tvalid,
	input  logic                    c_s_axis_tlast,
	output logic [`CTRL_DATA_W-1:0] c_m_axis_tdata,
	output logic                    c_m_axis_tvalid,
	output logic                    c_m_axis_tlast
);
	localparam int G4_LSB = 8 * `C2_W;
	localparam int G6_LSB = G4_LSB + 8 * `C4_W;

	logic               advance;
	logic               tbl_we_off;
	logic               tbl_we_mask;
	logic [`TBL_AW-1:0] tbl_addr;
	tbl_entry_u         tbl_entry;
	phv_t               phv_q;
	logic               valid_q;
	off_entry_t         off_q;
	key_t               mask_q;
	wire key_t          field_bus;

	// whole key path stalls with downstream
	assign advance = ready_in;
	assign ready_out = ready_in;

	ctrl_table_writer ctrl_table_writer_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.c_s_axis_tdata  (c_s_axis_tdata),
		.c_s_axis_tvalid (c_s_axis_tvalid),
		.c_s_axis_tlast  (c_s_axis_tlast),
		.c_m_axis_tdata  (c_m_axis_tdata),
		.c_m_axis_tvalid (c_m_axis_tvalid),
		.c_m_axis_tlast  (c_m_axis_tlast),
		.tbl_we_off      (tbl_we_off),
		.tbl_we_mask     (tbl_we_mask),
		.tbl_addr        (tbl_addr),
		.tbl_entry       (tbl_entry)
	);

	key_lookup key_lookup_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.advance      (advance),
		.vlan_in      (vlan_in),
		.phv_in       (phv_in),
		.phv_valid_in (phv_valid_in),
		.tbl_we_off   (tbl_we_off),
		.tbl_we_mask  (tbl_we_mask),
		.tbl_addr     (tbl_addr),
		.tbl_entry    (tbl_entry),
		.phv_q        (phv_q),
		.valid_q      (valid_q),
		.off_q        (off_q),
		.mask_q       (mask_q)
	);

	// fields 0,1 from 6B group, 2,3 from 4B, 4,5 from 2B
	for (genvar i = 0; i < 6; i++) begin : g_field
		localparam int FW = (i < 2) ? `C6_W : (i < 4) ? `C4_W : `C2_W;
		localparam int GRP_LSB = (i < 2) ? G6_LSB : (i < 4) ? G4_LSB : 0;
		localparam int KEY_LSB = (i < 2) ? `KEY_W - (i + 1) * `C6_W :
			(i < 4) ? 2 * `C2_W + (3 - i) * `C4_W : (5 - i) * `C2_W;

		key_field_select #(.FIELD_W(FW)) key_field_select_inst (
			.clk     (clk),
			.rst_n   (rst_n),
			.advance (advance),
			.group   (phv_q[GRP_LSB +: 8*FW]),
			.sel     (off_q[`OFF_W-1-`SEL_W*i -: `SEL_W]),
			.mask    (mask_q[KEY_LSB +: FW]),
			.field   (field_bus[KEY_LSB +: FW])
		);
	end

	key_assemble key_assemble_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.advance        (advance),
		.phv_q          (phv_q),
		.valid_q        (valid_q),
		.field_6b_0     (field_bus.f6_0),
		.field_6b_1     (field_bus.f6_1),
		.field_4b_0     (field_bus.f4_0),
		.field_4b_1     (field_bus.f4_1),
		.field_2b_0     (field_bus.f2_0),
		.field_2b_1     (field_bus.f2_1),
		.phv_out        (phv_out),
		.phv_valid_out  (phv_valid_out),
		.key_out_masked (key_out_masked),
		.key_valid_out  (key_valid_out)
	);

endmodule

// ==== tests/key_extract_sva.sv ====
`timescale 1ns/1ps
`include "key_extract_consts.svh"

module key_extract_sva (
	input logic              clk,
	input logic              rst_n,
	input logic              ready_in,
	input logic              phv_valid_out,
	input logic              key_valid_out,
	input logic [`PHV_W-1:0] phv_out,
	input logic [`KEY_W-1:0] key_out_masked,
	input logic              c_m_axis_tvalid,
	input logic              tbl_we_off,
	input logic              tbl_we_mask
);

	valid_pair: assert property (@(posedge clk) disable iff (!rst_n)
		phv_valid_out == key_valid_out)
		else $error("phv and key valid outputs differ");

	// output held under stall
	hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		phv_valid_out && !ready_in |=>
		phv_valid_out && $stable(phv_out) && $stable(key_out_masked))
		else $error("output changed while stalled");

	no_fwd_on_write: assert property (@(posedge clk) disable iff (!rst_n)
		(tbl_we_off || tbl_we_mask) |-> !c_m_axis_tvalid)
		else $error("control beat forwarded during a table write");

endmodule

bind key_extract_top key_extract_sva key_extract_sva_inst (.*);

// ==== tests/key_extract_tb.sv ====
`timescale 1ns/1ps
`include "key_extract_consts.svh"

module key_extract_tb;

	logic                    clk;
	logic                    rst_n;
	logic [`VLAN_W-1:0]      vlan_in;
	logic [`PHV_W-1:0]       phv_in;
	logic                    phv_valid_in;
	logic                    ready_in;
	logic                    ready_out;
	logic [`PHV_W-1:0]       phv_out;
	logic                    phv_valid_out;
	logic [`KEY_W-1:0]       key_out_masked;
	logic                    key_valid_out;
	logic [`CTRL_DATA_W-1:0] c_s_axis_tdata;
	logic                    c_s_axis_tvalid;
	logic                    c_s_axis_tlast;
	logic [`CTRL_DATA_W-1:0] c_m_axis_tdata;
	logic                    c_m_axis_tvalid;
	logic                    c_m_axis_tlast;

	// expected outputs in input order
	logic [`PHV_W-1:0]       exp_phv[$];
	logic [`KEY_W-1:0]       exp_key[$];
	int                      exp_cyc[$];
	bit                      exp_timed[$];
	int                      errors;
	int                      checks;
	int                      cyc;
	int                      fd;
	integer                  seed;
	bit                      rand_ready;
	bit                      phv_active;
	bit                      timed_out;
	logic [`CTRL_DATA_W-1:0] prev_data;
	bit                      prev_last;
	bit                      prev_fwd;

	key_extract_top key_extract_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// downstream back-pressure
	initial begin
		ready_in <= 1'b1;
		forever begin
			@(posedge clk);
			if (rand_ready) begin
				ready_in <= (($random(seed) & 32'd3) != 32'd0);
			end else begin
				ready_in <= 1'b1;
			end
		end
	end

	// ======================================================================
	// output monitor sampled mid-cycle
	// ======================================================================
	always @(negedge clk) begin
		cyc++;
		if (rst_n) begin
			checks++;
			assert (ready_out == ready_in) else begin
				errors++;
				$display("FAILED %0t: ready_out %b with ready_in %b", $time, ready_out,
					ready_in);
			end
		end
		if (rst_n && phv_valid_out && ready_in) begin
			checks++;
			assert (exp_phv.size() > 0) else begin
				errors++;
				$display("FAILED %0t: output with no packet outstanding", $time);
			end
			if (exp_phv.size() > 0) begin
				assert (phv_out == exp_phv[0] && key_out_masked == exp_key[0] && key_valid_out)
				else begin
					errors++;
					$display("FAILED %0t: key %h expected %h", $time, key_out_masked, exp_key[0]);
				end
				// three cycles from acceptance with ready held high
				assert (!exp_timed[0] || (cyc - exp_cyc[0] == 3)) else begin
					errors++;
					$display("FAILED %0t: latency %0d cycles", $time, cyc - exp_cyc[0]);
				end
				void'(exp_phv.pop_front());
				void'(exp_key.pop_front());
				void'(exp_cyc.pop_front());
				void'(exp_timed.pop_front());
			end
		end
	end

	task automatic report_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("timeout while waiting for %s", what);
	endtask

	task automatic check_forwarded();
		checks++;
		assert (c_m_axis_tvalid == prev_fwd &&
			(!prev_fwd || (c_m_axis_tdata == prev_data && c_m_axis_tlast == prev_last)))
		else begin
			errors++;
			$display("FAILED %0t: c_m beat %h valid %b", $time, c_m_axis_tdata, c_m_axis_tvalid);
		end
	endtask

	task automatic send_ctrl(input logic [`CTRL_DATA_W-1:0] d, input bit l, input bit f,
		input bit v);
		@(posedge clk);
		c_s_axis_tdata <= d;
		c_s_axis_tvalid <= v;
		c_s_axis_tlast <= l;
		@(negedge clk);
		check_forwarded();
		prev_data = d;
		prev_last = l;
		prev_fwd = f;
	endtask

	task automatic send_phv(input logic [`VLAN_W-1:0] v, input logic [`PHV_W-1:0] p,
		input logic [`KEY_W-1:0] k);
		int t;
		if (!phv_active) begin
			@(posedge clk);
		end
		phv_active = 1'b1;
		phv_valid_in <= 1'b1;
		vlan_in <= v;
		phv_in <= p;
		t = 0;
		do begin
			@(posedge clk);
			t++;
		end while (!ready_out && t < 200);
		if (!ready_out) begin
			report_timeout("input acceptance");
		end else begin
			exp_phv.push_back(p);
			exp_key.push_back(k);
			exp_cyc.push_back(cyc);
			exp_timed.push_back(!rand_ready);
		end
	endtask

	task automatic drain_pipeline();
		int t;
		phv_valid_in <= 1'b0;
		phv_active = 1'b0;
		t = 0;
		while (exp_phv.size() > 0 && t < 500) begin
			@(negedge clk);
			t++;
		end
		if (exp_phv.size() > 0) begin
			report_timeout("pipeline drain");
		end
	endtask

	initial begin
		string                   tag;
		logic [8*80-1:0]         line;
		logic [`CTRL_DATA_W-1:0] d;
		int                      l;
		int                      f;
		int                      r;
		logic [`VLAN_W-1:0]      v;
		logic [`PHV_W-1:0]       p;
		logic [`KEY_W-1:0]       k;
		seed = 32'hcb1dec05;
		errors = 0;
		checks = 0;
		cyc = 0;
		rand_ready = 1'b0;
		phv_active = 1'b0;
		timed_out = 1'b0;
		prev_fwd = 1'b0;
		rst_n <= 1'b0;
		vlan_in <= '0;
		phv_in <= '0;
		phv_valid_in <= 1'b0;
		c_s_axis_tdata <= '0;
		c_s_axis_tvalid <= 1'b0;
		c_s_axis_tlast <= 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		checks++;
		assert (!phv_valid_out && !key_valid_out && !c_m_axis_tvalid) else begin
			errors++;
			$display("FAILED %0t: valid output high after reset", $time);
		end
		fd = $fopen("tests/key_extract_stimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("stimulus file could not be opened");
		end else begin
			while (!timed_out && $fscanf(fd, "%s", tag) == 1) begin
				if (tag == "#") begin
					r = $fgets(line, fd);
				end else if (tag == "C") begin
					r = $fscanf(fd, "%h %d %d", d, l, f);
					send_ctrl(d, l[0], f[0], 1'b1);
				end else if (tag == "P") begin
					r = $fscanf(fd, "%h %h %h", v, p, k);
					// idle beat flushes the last forwarding check
					if (!phv_active) begin
						send_ctrl('0, 1'b0, 1'b0, 1'b0);
					end
					send_phv(v, p, k);
				end else if (tag == "R") begin
					r = $fscanf(fd, "%d", l);
					drain_pipeline();
					rand_ready = l[0];
				end
			end
			$fclose(fd);
			if (!timed_out) begin
				drain_pipeline();
			end
		end
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$display("checks %0d, errors %0d", checks, errors);
		$finish;
	end

endmodule

// ==== tests/key_extract_stimulus.txt ====
# C tdata tlast fwd : fwd means the beat shows on c_m_axis one cycle later
# P vlan phv key : R 1 switches ready_in to random
C 00000000000000000000000000000002000100000000f2f10000000000000000 0 0
C 000000000000000000000000000000000000000000000000000000000080cb29 0 0
C 00000000000000000000000000000000000000000000000000000000004074e0 1 0
C 00000000000000000000000000000002010100000000f2f10000000000000000 0 0
C 0000000000000000ffffffffffffffffffffffffffffffffffffffffffffffff 0 0
C 00000000000000000f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f 1 0
C 00000000000000000000000000000002000200000000f2f10000000000000000 0 1
C 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef 1 1
C 00000000000000000000000000000002000100000000f2f00000000000000000 1 1
C 00000000000000000000000000000002000100000000f2f10000000000000000 1 1
P 025 161616161607161616161606161616161605161616161604161616161603161616161602161616161601161616161600141414071414140614141405141414041414140314141402141414011414140012071206120512041203120212011200 161616161601161616161602141414031414140412051206
P 03a 262626262607262626262606262626262605262626262604262626262603262626262602262626262601262626262600242424072424240624242405242424042424240324242402242424012424240022072206220522042203220222012200 060606060607060606060600040404000404040702020201
P 233 363636363607363636363606363636363605363636363604363636363603363636363602363636363601363636363600343434073434340634343405343434043434340334343402343434013434340032073206320532043203320232013200 060606060607060606060600040404000404040702020201
R 1
P 02f 464646464607464646464606464646464605464646464604464646464603464646464602464646464601464646464600444444074444440644444405444444044444440344444402444444014444440042074206420542044203420242014200 464646464601464646464602444444034444440442054206
P 030 565656565607565656565606565656565605565656565604565656565603565656565602565656565601565656565600545454075454540654545405545454045454540354545402545454015454540052075206520552045203520252015200 060606060607060606060600040404000404040702020201
P 22c 666666666607666666666606666666666605666666666604666666666603666666666602666666666601666666666600646464076464640664646405646464046464640364646402646464016464640062076206620562046203620262016200 666666666601666666666602646464036464640462056206

// ==== key_extract_top.f ====
+incdir+source
source/phv_pkg.sv
source/ctrl_pkg.sv
source/key_field_select.sv
source/key_lookup.sv
source/ctrl_table_writer.sv
source/key_assemble.sv
source/key_extract_top.sv
tests/key_extract_sva.sv
tests/key_extract_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f key_extract_top.f \
	--top-module key_extract_tb -o key_extract_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/key_extract_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1
